/* include/issue_cfg.svh */
/*
  Issue stage sizes. ISSUE_NR_ENTRIES must equal 2**ISSUE_TRANS_ID_BITS
  because the scoreboard slot index doubles as the transaction ID.
*/
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

`define ISSUE_NR_ENTRIES    4
`define ISSUE_TRANS_ID_BITS 2
`define ISSUE_NR_WB_PORTS   2
`define ISSUE_XLEN          32

`endif

/* src/issue_pkg.sv */
/*
  Types shared by the issue stage. Widths come from issue_cfg.svh.
  No floating point, no rs3, no exception fields.
*/
`include "issue_cfg.svh"

package issue_pkg;

    // Functional-unit class of an instruction
    typedef enum logic [2:0] {
        FU_NONE = 3'd0,
        FU_ALU  = 3'd1,
        FU_LSU  = 3'd2,
        FU_MULT = 3'd3,
        FU_CSR  = 3'd4
    } fu_t;

    typedef struct packed {
        fu_t                     fu;
        logic [7:0]              op;
        logic [4:0]              rd;
        logic [4:0]              rs1;
        logic [4:0]              rs2;
        logic                    use_imm;
        logic [`ISSUE_XLEN-1:0]  imm;
        logic [`ISSUE_XLEN-1:0]  pc;
    } sb_entry_t;

    // Scoreboard head as seen by the commit logic
    typedef struct packed {
        logic                    valid;
        sb_entry_t               instr;
        logic [`ISSUE_XLEN-1:0]  result;
    } commit_t;

    typedef struct packed {
        logic                    busy;
        logic                    fwd;
        logic [`ISSUE_XLEN-1:0]  value;
    } src_status_t;

    typedef struct packed {
        logic                            valid;
        logic [`ISSUE_TRANS_ID_BITS-1:0] trans_id;
        logic [`ISSUE_XLEN-1:0]          data;
    } wb_port_t;

    typedef struct packed {
        fu_t                             fu;
        logic [7:0]                      op;
        logic [`ISSUE_XLEN-1:0]          operand_a;
        logic [`ISSUE_XLEN-1:0]          operand_b;
        logic [`ISSUE_XLEN-1:0]          imm;
        logic [`ISSUE_TRANS_ID_BITS-1:0] trans_id;
        logic [`ISSUE_XLEN-1:0]          pc;
    } fu_data_t;

endpackage

/* src/gpr_file.sv */
/*
  32 x 32 general-purpose registers, two asynchronous read ports.
  Written from the scoreboard head on commit acknowledge; x0 reads zero.
*/
`timescale 1ns/1ps
`include "issue_cfg.svh"

module gpr_file import issue_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic [4:0]             raddr1_i,
    input  logic [4:0]             raddr2_i,
    output logic [`ISSUE_XLEN-1:0] rdata1_o,
    output logic [`ISSUE_XLEN-1:0] rdata2_o,
    input  commit_t                commit_i,
    input  logic                   commit_ack_i
);

    logic [`ISSUE_XLEN-1:0] regs_q [32];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int r = 0; r < 32; r++) begin
                regs_q[r] <= '0;
            end
        end else if (commit_ack_i && commit_i.valid && commit_i.instr.rd != 5'd0) begin
            regs_q[commit_i.instr.rd] <= commit_i.result;
        end
    end

    assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs_q[raddr2_i];

endmodule

/* src/scoreboard.sv */
/*
  Four-slot ring buffer of in-flight instructions.
  Slots are allocated, issued and committed strictly in order; write-back
  may arrive in any order, addressed by slot index.
  Results become forwardable the cycle after write-back.
*/
`timescale 1ns/1ps
`include "issue_cfg.svh"

module scoreboard import issue_pkg::*; (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                flush_i,
    input  logic                                alloc_i,
    input  sb_entry_t                           decoded_instr_i,
    output logic                                sb_full_o,
    output sb_entry_t                           issue_entry_o,
    output logic                                issue_entry_valid_o,
    output logic [`ISSUE_TRANS_ID_BITS-1:0]     issue_id_o,
    input  logic                                issue_fire_i,
    output src_status_t                         rs1_status_o,
    output src_status_t                         rs2_status_o,
    input  wb_port_t [`ISSUE_NR_WB_PORTS-1:0]   wb_i,
    output commit_t                             commit_o,
    input  logic                                commit_ack_i
);

    localparam int TB = `ISSUE_TRANS_ID_BITS;

    sb_entry_t              entry_q  [`ISSUE_NR_ENTRIES];
    logic [`ISSUE_XLEN-1:0] result_q [`ISSUE_NR_ENTRIES];
    logic [`ISSUE_NR_ENTRIES-1:0] valid_q;
    logic [`ISSUE_NR_ENTRIES-1:0] issued_q;
    logic [`ISSUE_NR_ENTRIES-1:0] done_q;
    logic [TB-1:0] commit_ptr_q;
    logic [TB-1:0] issue_ptr_q;
    logic [TB-1:0] alloc_ptr_q;
    logic [TB-1:0] n_older;

    // Youngest issued producer of rs among the entries older than the issue head
    function automatic src_status_t lookup(input logic [4:0] rs);
        src_status_t st;
        logic [TB-1:0] idx;
        st = '0;
        for (int i = 0; i < `ISSUE_NR_ENTRIES; i++) begin
            idx = commit_ptr_q + TB'(i);
            if (i < int'(n_older) && valid_q[idx] && issued_q[idx] &&
                rs != 5'd0 && entry_q[idx].rd == rs) begin
                st.busy  = ~done_q[idx];
                st.fwd   = done_q[idx];
                st.value = result_q[idx];
            end
        end
        return st;
    endfunction

    assign n_older   = issue_ptr_q - commit_ptr_q;
    assign sb_full_o = valid_q[alloc_ptr_q];

    assign issue_entry_o       = entry_q[issue_ptr_q];
    assign issue_entry_valid_o = valid_q[issue_ptr_q] & ~issued_q[issue_ptr_q];
    assign issue_id_o          = issue_ptr_q;

    assign commit_o.valid  = valid_q[commit_ptr_q] & done_q[commit_ptr_q];
    assign commit_o.instr  = entry_q[commit_ptr_q];
    assign commit_o.result = result_q[commit_ptr_q];

    always_comb begin
        rs1_status_o = lookup(issue_entry_o.rs1);
        rs2_status_o = lookup(issue_entry_o.rs2);
    end

    // --------------------
    // Slot state
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            valid_q      <= '0;
            issued_q     <= '0;
            done_q       <= '0;
            commit_ptr_q <= '0;
            issue_ptr_q  <= '0;
            alloc_ptr_q  <= '0;
        end else begin
            // Retire the head
            if (commit_ack_i && commit_o.valid) begin
                valid_q[commit_ptr_q]  <= 1'b0;
                issued_q[commit_ptr_q] <= 1'b0;
                done_q[commit_ptr_q]   <= 1'b0;
                commit_ptr_q           <= commit_ptr_q + 1'b1;
            end
            if (issue_fire_i) begin
                issued_q[issue_ptr_q] <= 1'b1;
                issue_ptr_q           <= issue_ptr_q + 1'b1;
            end
            for (int p = 0; p < `ISSUE_NR_WB_PORTS; p++) begin
                if (wb_i[p].valid) begin
                    done_q[wb_i[p].trans_id] <= 1'b1;
                end
            end
            // Only a free slot is ever allocated
            if (alloc_i) begin
                valid_q[alloc_ptr_q] <= 1'b1;
                alloc_ptr_q          <= alloc_ptr_q + 1'b1;
            end
        end
    end

    // Payload storage
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            entry_q[alloc_ptr_q] <= decoded_instr_i;
        end
        for (int p = 0; p < `ISSUE_NR_WB_PORTS; p++) begin
            if (wb_i[p].valid) begin
                result_q[wb_i[p].trans_id] <= wb_i[p].data;
            end
        end
    end

endmodule

/* src/operand_read.sv */
/*
  Operand selection for the issuing instruction.
  A forwarded scoreboard result wins over the register file.
  The unit bundle is registered on issue_fire_i and held otherwise.
*/
`timescale 1ns/1ps
`include "issue_cfg.svh"

module operand_read import issue_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             flush_i,
    input  sb_entry_t                        issue_entry_i,
    input  logic [`ISSUE_TRANS_ID_BITS-1:0]  issue_id_i,
    input  logic                             issue_fire_i,
    input  src_status_t                      rs1_status_i,
    input  src_status_t                      rs2_status_i,
    output logic [4:0]                       rf_raddr1_o,
    output logic [4:0]                       rf_raddr2_o,
    input  logic [`ISSUE_XLEN-1:0]           rf_rdata1_i,
    input  logic [`ISSUE_XLEN-1:0]           rf_rdata2_i,
    output fu_data_t                         fu_data_o
);

    logic [`ISSUE_XLEN-1:0] operand_a;
    logic [`ISSUE_XLEN-1:0] rs2_value;
    logic [`ISSUE_XLEN-1:0] operand_b;
    fu_data_t               fu_data_q;

    assign rf_raddr1_o = issue_entry_i.rs1;
    assign rf_raddr2_o = issue_entry_i.rs2;

    // --------------------
    // Operand muxes
    // --------------------
    assign operand_a = rs1_status_i.fwd ? rs1_status_i.value : rf_rdata1_i;
    assign rs2_value = rs2_status_i.fwd ? rs2_status_i.value : rf_rdata2_i;
    assign operand_b = issue_entry_i.use_imm ? issue_entry_i.imm : rs2_value;

    // Unit class is cleared so a stale bundle never looks like a live op
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            fu_data_q.fu <= FU_NONE;
        end else if (issue_fire_i) begin
            fu_data_q.fu <= issue_entry_i.fu;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_fire_i) begin
            fu_data_q.op        <= issue_entry_i.op;
            fu_data_q.operand_a <= operand_a;
            fu_data_q.operand_b <= operand_b;
            fu_data_q.imm       <= issue_entry_i.imm;
            fu_data_q.trans_id  <= issue_id_i;
            fu_data_q.pc        <= issue_entry_i.pc;
        end
    end

    assign fu_data_o = fu_data_q;

endmodule

/* src/issue_ctrl.sv */
/*
  Issue decision for the head of the unissued queue.
  ALU, MULT and CSR share flu_ready_i. Unit valid strobes are registered,
  so they follow issue_fire_o by one cycle.
*/
`timescale 1ns/1ps

module issue_ctrl import issue_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        flush_i,
    input  logic        decoded_valid_i,
    input  logic        sb_full_i,
    output logic        alloc_o,
    input  sb_entry_t   issue_entry_i,
    input  logic        issue_entry_valid_i,
    input  src_status_t rs1_status_i,
    input  src_status_t rs2_status_i,
    input  logic        flu_ready_i,
    input  logic        lsu_ready_i,
    output logic        issue_fire_o,
    output logic        alu_valid_o,
    output logic        lsu_valid_o,
    output logic        mult_valid_o,
    output logic        csr_valid_o,
    output logic        stall_issue_o
);

    logic unit_ready;
    logic srcs_ready;

    // Accept from the decoder while a slot is free
    assign alloc_o = decoded_valid_i & ~sb_full_i & ~flush_i;

    // --------------------
    // Issue decision
    // --------------------
    always_comb begin
        case (issue_entry_i.fu)
            FU_LSU:  unit_ready = lsu_ready_i;
            // ALU, MULT and CSR share one ready; FU_NONE raises no strobe
            default: unit_ready = flu_ready_i;
        endcase
    end

    assign srcs_ready   = ~rs1_status_i.busy & ~rs2_status_i.busy;
    assign issue_fire_o = issue_entry_valid_i & srcs_ready & unit_ready & ~flush_i;

    // Head is present but held back by a busy source or a unit
    assign stall_issue_o = issue_entry_valid_i & ~issue_fire_o & ~flush_i;

    // --------------------
    // Unit strobes
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            alu_valid_o  <= 1'b0;
            lsu_valid_o  <= 1'b0;
            mult_valid_o <= 1'b0;
            csr_valid_o  <= 1'b0;
        end else begin
            alu_valid_o  <= issue_fire_o & (issue_entry_i.fu == FU_ALU);
            lsu_valid_o  <= issue_fire_o & (issue_entry_i.fu == FU_LSU);
            mult_valid_o <= issue_fire_o & (issue_entry_i.fu == FU_MULT);
            csr_valid_o  <= issue_fire_o & (issue_entry_i.fu == FU_CSR);
        end
    end

endmodule

/* src/issue_stage.sv */
/*
  In-order issue stage with a four-entry scoreboard.
  One issue per cycle, one commit port, two write-back ports.
  Write-back trans_id is the scoreboard slot index.
  commit_ack_i is only legal while commit_o.valid is high.
*/
`timescale 1ns/1ps
`include "issue_cfg.svh"

module issue_stage import issue_pkg::*; (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                flush_i,
    // Decoder side
    input  sb_entry_t                           decoded_instr_i,
    input  logic                                decoded_valid_i,
    output logic                                decoded_ack_o,
    output logic                                sb_full_o,
    // Functional units
    input  logic                                flu_ready_i,
    input  logic                                lsu_ready_i,
    output fu_data_t                            fu_data_o,
    output logic                                alu_valid_o,
    output logic                                lsu_valid_o,
    output logic                                mult_valid_o,
    output logic                                csr_valid_o,
    output logic                                stall_issue_o,
    // Write-back and commit
    input  wb_port_t [`ISSUE_NR_WB_PORTS-1:0]   wb_i,
    output commit_t                             commit_o,
    input  logic                                commit_ack_i
);

    // --------------------
    // Internal wiring
    // --------------------
    sb_entry_t                        issue_entry;
    logic                             issue_entry_valid;
    logic [`ISSUE_TRANS_ID_BITS-1:0]  issue_id;
    src_status_t                      rs1_status;
    src_status_t                      rs2_status;
    logic                             issue_fire;
    logic                             alloc;
    logic [4:0]                       rf_raddr1;
    logic [4:0]                       rf_raddr2;
    logic [`ISSUE_XLEN-1:0]           rf_rdata1;
    logic [`ISSUE_XLEN-1:0]           rf_rdata2;

    assign decoded_ack_o = alloc;

    issue_ctrl u_issue_ctrl (
        .clk_i               ( clk_i             ),
        .rst_i               ( rst_i             ),
        .flush_i             ( flush_i           ),
        .decoded_valid_i     ( decoded_valid_i   ),
        .sb_full_i           ( sb_full_o         ),
        .alloc_o             ( alloc             ),
        .issue_entry_i       ( issue_entry       ),
        .issue_entry_valid_i ( issue_entry_valid ),
        .rs1_status_i        ( rs1_status        ),
        .rs2_status_i        ( rs2_status        ),
        .flu_ready_i         ( flu_ready_i       ),
        .lsu_ready_i         ( lsu_ready_i       ),
        .issue_fire_o        ( issue_fire        ),
        .alu_valid_o         ( alu_valid_o       ),
        .lsu_valid_o         ( lsu_valid_o       ),
        .mult_valid_o        ( mult_valid_o      ),
        .csr_valid_o         ( csr_valid_o       ),
        .stall_issue_o       ( stall_issue_o     )
    );

    scoreboard u_scoreboard (
        .clk_i               ( clk_i             ),
        .rst_i               ( rst_i             ),
        .flush_i             ( flush_i           ),
        .alloc_i             ( alloc             ),
        .decoded_instr_i     ( decoded_instr_i   ),
        .sb_full_o           ( sb_full_o         ),
        .issue_entry_o       ( issue_entry       ),
        .issue_entry_valid_o ( issue_entry_valid ),
        .issue_id_o          ( issue_id          ),
        .issue_fire_i        ( issue_fire        ),
        .rs1_status_o        ( rs1_status        ),
        .rs2_status_o        ( rs2_status        ),
        .wb_i                ( wb_i              ),
        .commit_o            ( commit_o          ),
        .commit_ack_i        ( commit_ack_i      )
    );

    operand_read u_operand_read (
        .clk_i         ( clk_i       ),
        .rst_i         ( rst_i       ),
        .flush_i       ( flush_i     ),
        .issue_entry_i ( issue_entry ),
        .issue_id_i    ( issue_id    ),
        .issue_fire_i  ( issue_fire  ),
        .rs1_status_i  ( rs1_status  ),
        .rs2_status_i  ( rs2_status  ),
        .rf_raddr1_o   ( rf_raddr1   ),
        .rf_raddr2_o   ( rf_raddr2   ),
        .rf_rdata1_i   ( rf_rdata1   ),
        .rf_rdata2_i   ( rf_rdata2   ),
        .fu_data_o     ( fu_data_o   )
    );

    gpr_file u_gpr_file (
        .clk_i        ( clk_i        ),
        .rst_i        ( rst_i        ),
        .raddr1_i     ( rf_raddr1    ),
        .raddr2_i     ( rf_raddr2    ),
        .rdata1_o     ( rf_rdata1    ),
        .rdata2_o     ( rf_rdata2    ),
        .commit_i     ( commit_o     ),
        .commit_ack_i ( commit_ack_i )
    );

endmodule

/* tb/tb_issue_stage.sv */
/*
  Directed testbench for issue_stage with a shadow register file and a
  unit model: ALU op 0 adds, every other op XORs operand A and B.
  Inputs change 1 ns after the rising edge, outputs are sampled 1 ns later.
  Trans IDs are predicted from a local allocation counter.
*/
`timescale 1ns/1ps
`include "issue_cfg.svh"

module tb_issue_stage import issue_pkg::*; ();

    localparam int CLK_NS      = 4;
    localparam int NR_TESTS    = 6;
    localparam int TEST_CYCLES = 400;
    localparam int MAX_WAIT    = 20;
    localparam int IDW         = `ISSUE_TRANS_ID_BITS;

    typedef struct packed {
        logic [IDW-1:0] id;
        logic [4:0]     rd;
        logic [31:0]    result;
        logic [31:0]    pc;
    } op_rec_t;

    logic clk_i, rst_i, flush_i;
    sb_entry_t decoded_instr_i;
    logic decoded_valid_i, decoded_ack_o, sb_full_o;
    logic flu_ready_i, lsu_ready_i;
    fu_data_t fu_data_o;
    logic alu_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o, stall_issue_o;
    wb_port_t [`ISSUE_NR_WB_PORTS-1:0] wb_i;
    commit_t commit_o;
    logic commit_ack_i;

    // Model state
    logic [31:0]    shadow_regs [32];
    op_rec_t        inflight [$];
    logic [IDW-1:0] alloc_id;
    logic [31:0]    lfsr_q;
    int             checks;
    int             errors;

    issue_stage u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    initial begin
        #(NR_TESTS * TEST_CYCLES * CLK_NS);
        $display("ERROR: watchdog expired, the tests did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    // --------------------
    // Helpers
    // --------------------
    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] unit_result(input fu_t fu, input logic [7:0] op,
                                                input logic [31:0] a, input logic [31:0] b);
        return (fu == FU_ALU && op == 8'd0) ? a + b : a ^ b;
    endfunction

    function automatic sb_entry_t make_instr(input fu_t fu, input logic [7:0] op,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic use_imm,
                                             input logic [31:0] imm, input logic [31:0] pc);
        return '{fu: fu, op: op, rd: rd, rs1: rs1, rs2: rs2, use_imm: use_imm,
                 imm: imm, pc: pc};
    endfunction

    task automatic expect_eq(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s %s expected 0x%08h actual 0x%08h", name, what, exp, act);
        end
    endtask

    task automatic report_failure(input string name, input string msg);
        errors++;
        $display("ERROR %s: %s", name, msg);
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_idle(input string name);
        #1;
        checks++;
        if ({alu_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o, decoded_ack_o,
             stall_issue_o, commit_o.valid, sb_full_o} != 8'b0) begin
            report_failure(name, "outputs not idle after reset or flush");
        end
        next_cycle();
    endtask

    // Present one instruction and hold it until the acknowledge
    task automatic dispatch(input string name, input sb_entry_t instr,
                            output logic [IDW-1:0] id);
        bit accepted;
        accepted        = 1'b0;
        id              = alloc_id;
        decoded_instr_i = instr;
        decoded_valid_i = 1'b1;
        for (int n = 0; n < MAX_WAIT && !accepted; n++) begin
            #1;
            accepted = decoded_ack_o;
            next_cycle();
        end
        decoded_valid_i = 1'b0;
        if (accepted) begin
            alloc_id = alloc_id + 1'b1;
        end else begin
            report_failure(name, "decoded instruction not acknowledged within 20 cycles");
        end
    endtask

    // Wait for the unit pulse, check the bundle, then record the model result
    task automatic issue_check(input string name, input sb_entry_t instr,
                               input logic [IDW-1:0] id,
                               input logic [31:0] exp_a, input logic [31:0] exp_b);
        fu_data_t   d;
        logic [3:0] strobes;
        logic [3:0] exp_strobes;
        bit         seen;
        seen        = 1'b0;
        exp_strobes = 4'b0001 << (int'(instr.fu) - 1);
        for (int n = 0; n < MAX_WAIT && !seen; n++) begin
            #1;
            strobes = {csr_valid_o, mult_valid_o, lsu_valid_o, alu_valid_o};
            if (strobes != 4'b0) begin
                seen = 1'b1;
                d    = fu_data_o;
            end
            next_cycle();
        end
        if (!seen) begin
            report_failure(name, "no unit valid pulse within 20 cycles");
            return;
        end
        expect_eq(name, "unit strobes", exp_strobes, strobes);
        expect_eq(name, "fu", instr.fu, d.fu);
        expect_eq(name, "op", instr.op, d.op);
        expect_eq(name, "operand_a", exp_a, d.operand_a);
        expect_eq(name, "operand_b", exp_b, d.operand_b);
        expect_eq(name, "imm", instr.imm, d.imm);
        expect_eq(name, "trans_id", id, d.trans_id);
        expect_eq(name, "pc", instr.pc, d.pc);
        #1;
        checks++;
        if (alu_valid_o || lsu_valid_o || mult_valid_o || csr_valid_o) begin
            report_failure(name, "more than one unit valid pulse for a single issue");
        end
        next_cycle();
        inflight.push_back('{id: id, rd: instr.rd,
                             result: unit_result(instr.fu, instr.op, exp_a, exp_b),
                             pc: instr.pc});
    endtask

    task automatic write_back(input int port, input op_rec_t rec);
        wb_port_t w;
        w          = '{valid: 1'b1, trans_id: rec.id, data: rec.result};
        wb_i[port] = w;
        next_cycle();
        wb_i[port] = '0;
    endtask

    // Oldest modeled entry must appear on commit_o, then acknowledge it
    task automatic retire(input string name);
        op_rec_t rec;
        bit      seen;
        seen = 1'b0;
        if (inflight.size() == 0) begin
            report_failure(name, "no modeled instruction left to retire");
            return;
        end
        rec = inflight.pop_front();
        for (int n = 0; n < MAX_WAIT && !seen; n++) begin
            #1;
            if (commit_o.valid) begin
                seen = 1'b1;
                expect_eq(name, "commit pc", rec.pc, commit_o.instr.pc);
                expect_eq(name, "commit rd", rec.rd, commit_o.instr.rd);
                expect_eq(name, "commit result", rec.result, commit_o.result);
            end
            next_cycle();
        end
        if (!seen) begin
            report_failure(name, "commit_o.valid not raised within 20 cycles");
            return;
        end
        commit_ack_i = 1'b1;
        next_cycle();
        commit_ack_i = 1'b0;
        if (rec.rd != 5'd0) begin
            shadow_regs[rec.rd] = rec.result;
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_basic();
        sb_entry_t      instr;
        logic [IDW-1:0] id;
        logic [31:0]    imm;
        imm   = rand_bits(32);
        instr = make_instr(FU_ALU, 8'd0, 5'd1, 5'd0, 5'd0, 1'b1, imm, 32'h1000);
        dispatch("basic", instr, id);
        issue_check("basic", instr, id, shadow_regs[0], imm);
        write_back(0, inflight[0]);
        retire("basic");
        // Later reader of x1 sees the committed value
        imm   = rand_bits(32);
        instr = make_instr(FU_ALU, 8'd1, 5'd2, 5'd1, 5'd0, 1'b1, imm, 32'h1004);
        dispatch("basic", instr, id);
        issue_check("basic", instr, id, shadow_regs[1], imm);
        write_back(1, inflight[0]);
        retire("basic");
    endtask

    task automatic test_raw();
        sb_entry_t      i1;
        sb_entry_t      i2;
        logic [IDW-1:0] id1;
        logic [IDW-1:0] id2;
        i1 = make_instr(FU_ALU, 8'd0, 5'd3, 5'd1, 5'd0, 1'b1, rand_bits(16), 32'h2000);
        dispatch("raw", i1, id1);
        issue_check("raw", i1, id1, shadow_regs[1], i1.imm);
        i2 = make_instr(FU_ALU, 8'd2, 5'd4, 5'd3, 5'd1, 1'b0, 32'h0, 32'h2004);
        dispatch("raw", i2, id2);
        for (int n = 0; n < 6; n++) begin
            #1;
            checks++;
            if (alu_valid_o || lsu_valid_o || mult_valid_o || csr_valid_o) begin
                report_failure("raw", "dependent instruction issued before write-back");
            end
            expect_eq("raw", "stall_issue_o", 32'd1, stall_issue_o);
            next_cycle();
        end
        write_back(1, inflight[0]);
        // Producer is still uncommitted, so rs1 must come from forwarding
        issue_check("raw", i2, id2, inflight[0].result, shadow_regs[1]);
        write_back(0, inflight[1]);
        retire("raw");
        retire("raw");
    endtask

    task automatic test_ooo();
        sb_entry_t      instr;
        logic [IDW-1:0] id;
        int             order [4];
        int             j;
        int             t;
        for (int k = 0; k < 4; k++) begin
            instr = make_instr(FU_ALU, 8'd0, 5'(5 + k), 5'(1 + k), 5'd0, 1'b1,
                               rand_bits(12), 32'h3000 + 32'(4 * k));
            dispatch("ooo", instr, id);
            issue_check("ooo", instr, id, shadow_regs[1 + k], instr.imm);
            order[k] = k;
        end
        for (int k = 3; k > 0; k--) begin
            j        = int'(rand_bits(2)) % (k + 1);
            t        = order[k];
            order[k] = order[j];
            order[j] = t;
        end
        for (int k = 0; k < 4; k++) begin
            write_back(int'(rand_bits(1)), inflight[order[k]]);
        end
        for (int k = 0; k < 4; k++) begin
            retire("ooo");
        end
    endtask

    task automatic test_backpressure();
        sb_entry_t      instr;
        logic [IDW-1:0] id;
        lsu_ready_i = 1'b0;
        instr = make_instr(FU_LSU, 8'd3, 5'd9, 5'd2, 5'd0, 1'b1, rand_bits(12), 32'h4000);
        dispatch("backpressure", instr, id);
        for (int n = 0; n < 8; n++) begin
            #1;
            checks++;
            if (lsu_valid_o) begin
                report_failure("backpressure", "lsu pulse while lsu_ready_i is low");
            end
            expect_eq("backpressure", "stall_issue_o", 32'd1, stall_issue_o);
            next_cycle();
        end
        lsu_ready_i = 1'b1;
        issue_check("backpressure", instr, id, shadow_regs[2], instr.imm);
        write_back(0, inflight[0]);
        retire("backpressure");
    endtask

    task automatic test_full();
        sb_entry_t      instr;
        sb_entry_t      extra;
        logic [IDW-1:0] id;
        for (int k = 0; k < 4; k++) begin
            instr = make_instr(FU_ALU, 8'd0, 5'(10 + k), 5'(5 + k), 5'd0, 1'b1,
                               rand_bits(12), 32'h5000 + 32'(4 * k));
            dispatch("full", instr, id);
            issue_check("full", instr, id, shadow_regs[5 + k], instr.imm);
        end
        for (int k = 0; k < 4; k++) begin
            write_back(k % 2, inflight[k]);
        end
        extra = make_instr(FU_ALU, 8'd1, 5'd14, 5'd10, 5'd0, 1'b1, rand_bits(12), 32'h5010);
        decoded_instr_i = extra;
        decoded_valid_i = 1'b1;
        for (int n = 0; n < 4; n++) begin
            #1;
            expect_eq("full", "sb_full_o", 32'd1, sb_full_o);
            expect_eq("full", "decoded_ack_o", 32'd0, decoded_ack_o);
            next_cycle();
        end
        // One retirement frees the slot for the waiting instruction
        retire("full");
        dispatch("full", extra, id);
        issue_check("full", extra, id, shadow_regs[10], extra.imm);
        write_back(1, inflight[3]);
        for (int k = 0; k < 4; k++) begin
            retire("full");
        end
    endtask

    task automatic test_flush();
        sb_entry_t      instr;
        logic [IDW-1:0] id;
        instr = make_instr(FU_ALU, 8'd0, 5'd15, 5'd6, 5'd0, 1'b1, rand_bits(12), 32'h6000);
        dispatch("flush", instr, id);
        issue_check("flush", instr, id, shadow_regs[6], instr.imm);
        instr = make_instr(FU_MULT, 8'd1, 5'd16, 5'd7, 5'd8, 1'b0, 32'h0, 32'h6004);
        dispatch("flush", instr, id);
        issue_check("flush", instr, id, shadow_regs[7], shadow_regs[8]);
        lsu_ready_i = 1'b0;
        instr = make_instr(FU_LSU, 8'd0, 5'd17, 5'd1, 5'd0, 1'b1, 32'h10, 32'h6008);
        dispatch("flush", instr, id);
        // Queued behind the stalled load so the scoreboard fills up
        instr = make_instr(FU_CSR, 8'd1, 5'd19, 5'd2, 5'd0, 1'b1, 32'h20, 32'h600c);
        dispatch("flush", instr, id);
        write_back(0, inflight[0]);
        #1;
        expect_eq("flush", "sb_full_o", 32'd1, sb_full_o);
        expect_eq("flush", "commit_o.valid", 32'd1, commit_o.valid);
        next_cycle();
        flush_i = 1'b1;
        next_cycle();
        flush_i     = 1'b0;
        lsu_ready_i = 1'b1;
        inflight.delete();
        alloc_id = '0;
        for (int n = 0; n < 6; n++) begin
            check_idle("flush");
        end
        // Registers committed before the flush keep their values
        instr = make_instr(FU_ALU, 8'd2, 5'd18, 5'd5, 5'd6, 1'b0, 32'h0, 32'h6010);
        dispatch("flush", instr, id);
        issue_check("flush", instr, id, shadow_regs[5], shadow_regs[6]);
        write_back(1, inflight[0]);
        retire("flush");
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        rst_i           = 1'b1;
        flush_i         = 1'b0;
        decoded_instr_i = '0;
        decoded_valid_i = 1'b0;
        flu_ready_i     = 1'b1;
        lsu_ready_i     = 1'b1;
        wb_i            = '0;
        commit_ack_i    = 1'b0;
        lfsr_q          = 32'd36;
        alloc_id        = '0;
        checks          = 0;
        errors          = 0;
        for (int r = 0; r < 32; r++) begin
            shadow_regs[r] = '0;
        end
        repeat (16) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        check_idle("reset");
        test_basic();
        test_raw();
        test_ooo();
        test_backpressure();
        test_full();
        test_flush();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* issue.f */
+incdir+include
src/issue_pkg.sv
src/gpr_file.sv
src/scoreboard.sv
src/operand_read.sv
src/issue_ctrl.sv
src/issue_stage.sv
tb/tb_issue_stage.sv

/* Makefile */
SRCS := $(wildcard include/*.svh src/*.sv tb/*.sv) issue.f

all: run

obj_dir/Vtb_issue_stage: $(SRCS)
	verilator --binary --timing -Wno-fatal -f issue.f --top-module tb_issue_stage

run: obj_dir/Vtb_issue_stage
	./obj_dir/Vtb_issue_stage | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
